// File: verilog/ahb_mem_pkg.sv
/*
 * Shared widths, AHB encodings and bus types for the dual-port memory model.
 * Only the low mem_addr_bits address bits reach the array, so addresses wrap.
 */

package ahb_mem_pkg;

    // ------------------------------------------------------------
    // Sizes and register map
    // ------------------------------------------------------------
    localparam int ahb_width     = 32;
    localparam int mem_addr_bits = 12;
    localparam int irq_lines_num = 8;

    localparam logic [ahb_width-1:0] irq_addr     = 32'hF000_0100;
    localparam logic [ahb_width-1:0] err_ptr_addr = 32'hF000_0200;
    // Also the reset value of the error pointer
    localparam logic [ahb_width-1:0] mem_err_addr = 32'hFFFF_F100;

    // ------------------------------------------------------------
    // AHB encodings
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        hsize_byte = 3'b000,
        hsize_half = 3'b001,
        hsize_word = 3'b010
    } hsize_e;

    typedef enum logic {
        hresp_okay  = 1'b0,
        hresp_error = 1'b1
    } hresp_e;

    // Address seen whole or as word index plus byte offset
    typedef union packed {
        logic [ahb_width-1:0] full;
        struct packed {
            logic [ahb_width-3:0] word;
            logic [1:0]           offset;
        } idx;
    } addr_word_u;

    typedef struct packed {
        htrans_e    htrans;
        addr_word_u haddr;
        logic       hwrite;
        hsize_e     hsize;
    } ahb_req_t;

    typedef struct packed {
        logic                 hready;
        hresp_e               hresp;
        logic [ahb_width-1:0] hrdata;
    } ahb_rsp_t;

    typedef struct packed {
        logic                     en;
        logic [mem_addr_bits-3:0] word;
        logic [3:0]               be;
    } mem_wr_t;

    typedef enum logic {
        state_idle = 1'b0,
        state_data = 1'b1
    } port_state_e;

endpackage

// File: verilog/ahb_ready_pacer.sv
/*
 * Ready pacing for one AHB port. The pattern is sampled while rst_n is low
 * and must stay stable then. A zero pattern keeps the port always ready.
 */

`timescale 1ns/1ps

module ahb_ready_pacer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pattern,
    output logic        ready
);

    logic [31:0] pattern_q;

    // Load during reset, rotate right every cycle afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pattern_q <= pattern;
        end else begin
            pattern_q <= {pattern_q[0], pattern_q[31:1]};
        end
    end

    // All-zero pattern would stall forever, treat it as no pacing
    assign ready = (pattern_q == '0) ? 1'b1 : pattern_q[0];

endmodule

// File: verilog/ahb_ifetch_port.sv
/*
 * Instruction-fetch AHB port, read only and always a full word.
 * hwrite and hsize of the request are ignored.
 */

`timescale 1ns/1ps

module ahb_ifetch_port import ahb_mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ahb_req_t                 req,
    input  logic                     ready,
    input  logic [ahb_width-1:0]     err_ptr,
    output logic [mem_addr_bits-3:0] rd_word,
    input  logic [ahb_width-1:0]     rd_data,
    output ahb_rsp_t                 rsp
);

    port_state_e          state_q;
    logic [ahb_width-1:0] addr_q;
    logic [ahb_width-1:0] rdata_q;
    logic                 accept;
    logic                 err_hit;

    // SEQ and NONSEQ start a transfer, IDLE and BUSY do not
    assign accept = ready && ((req.htrans == htrans_nonseq) || (req.htrans == htrans_seq));

    assign rd_word = req.haddr.idx.word[mem_addr_bits-3:0];

    // ------------------------------------------------------------
    // Phase tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= state_idle;
        end else if (ready) begin
            state_q <= accept ? state_data : state_idle;
        end
    end

    // Word is read in the address phase and held for the data phase
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req.haddr.full;
            rdata_q <= rd_data;
        end
    end

    // ------------------------------------------------------------
    // Response
    // ------------------------------------------------------------
    assign err_hit = (addr_q == mem_err_addr) || (addr_q == err_ptr);

    always_comb begin
        rsp.hready = ready;
        rsp.hresp  = hresp_okay;
        rsp.hrdata = '0;
        if ((state_q == state_data) && ready) begin
            if (err_hit) begin
                rsp.hresp = hresp_error;
            end else begin
                rsp.hrdata = rdata_q;
            end
        end
    end

endmodule

// File: verilog/ahb_data_port.sv
/*
 * Data AHB port with byte, half and word accesses and two mapped registers.
 * hwdata must stay stable through wait states, the array write is repeated.
 * Misaligned halfwords at offset 3 keep only the lane that fits the word.
 */

`timescale 1ns/1ps

module ahb_data_port import ahb_mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ahb_req_t                 req,
    input  logic [ahb_width-1:0]     hwdata,
    input  logic                     ready,
    output logic [mem_addr_bits-3:0] rd_word,
    output logic [3:0]               rd_be,
    input  logic [ahb_width-1:0]     rd_data,
    output mem_wr_t                  wr,
    output logic [ahb_width-1:0]     err_ptr,
    output logic [irq_lines_num-1:0] irq_lines,
    output ahb_rsp_t                 rsp
);

    port_state_e              state_q;
    addr_word_u               addr_q;
    logic                     wr_q;
    logic [3:0]               be_q;
    logic [ahb_width-1:0]     rdata_q;
    logic [irq_lines_num-1:0] irq_q;
    logic [ahb_width-1:0]     err_ptr_q;
    logic                     accept;
    logic                     in_data;
    logic                     done;
    logic                     err_hit;
    logic                     sel_irq;
    logic                     sel_err_ptr;
    logic                     sel_mem;

    assign accept  = ready && ((req.htrans == htrans_nonseq) || (req.htrans == htrans_seq));
    assign in_data = (state_q == state_data);
    assign done    = in_data && ready;

    // ------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------
    always_comb begin
        case (req.hsize)
            hsize_byte: rd_be = 4'b0001 << req.haddr.idx.offset;
            hsize_half: rd_be = 4'b0011 << req.haddr.idx.offset;
            default:    rd_be = 4'b1111;
        endcase
    end

    assign rd_word = req.haddr.idx.word[mem_addr_bits-3:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= state_idle;
        end else if (ready) begin
            state_q <= accept ? state_data : state_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req.haddr;
            wr_q    <= req.hwrite;
            be_q    <= rd_be;
            rdata_q <= rd_data;
        end
    end

    // ------------------------------------------------------------
    // Data phase decode
    // ------------------------------------------------------------
    assign err_hit     = (addr_q.full == mem_err_addr) || (addr_q.full == err_ptr_q);
    assign sel_irq     = (addr_q.full == irq_addr);
    assign sel_err_ptr = (addr_q.full == err_ptr_addr);
    assign sel_mem     = !sel_irq && !sel_err_ptr;

    // Announced for the whole data phase so a read accepted now sees it
    always_comb begin
        wr.en   = in_data && wr_q && sel_mem && !err_hit;
        wr.word = addr_q.idx.word[mem_addr_bits-3:0];
        wr.be   = be_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q     <= '0;
            err_ptr_q <= mem_err_addr;
        end else if (done && wr_q && !err_hit) begin
            if (sel_irq) begin
                irq_q <= hwdata[irq_lines_num-1:0];
            end
            if (sel_err_ptr) begin
                err_ptr_q <= hwdata;
            end
        end
    end

    assign irq_lines = irq_q;
    assign err_ptr   = err_ptr_q;

    // Register reads use the live value, so a write just before is seen
    always_comb begin
        rsp.hready = ready;
        rsp.hresp  = hresp_okay;
        rsp.hrdata = '0;
        if (done) begin
            if (err_hit) begin
                rsp.hresp = hresp_error;
            end else if (!wr_q) begin
                if (sel_irq) begin
                    rsp.hrdata[irq_lines_num-1:0] = irq_q;
                end else if (sel_err_ptr) begin
                    rsp.hrdata = err_ptr_q;
                end else begin
                    rsp.hrdata = rdata_q;
                end
            end
        end
    end

endmodule

// File: verilog/ahb_mem_array.sv
/*
 * Shared byte array, 2**mem_addr_bits bytes, no reset and no initial contents.
 * Reads are combinational and forward bytes of a pending data-port write.
 */

`timescale 1ns/1ps

module ahb_mem_array import ahb_mem_pkg::*; (
    input  logic                     clk,
    input  logic [mem_addr_bits-3:0] i_word,
    input  logic [mem_addr_bits-3:0] d_word,
    input  logic [3:0]               d_be,
    output logic [ahb_width-1:0]     i_data,
    output logic [ahb_width-1:0]     d_data,
    input  mem_wr_t                  wr,
    input  logic [ahb_width-1:0]     wdata
);

    logic [7:0] mem [0:2**mem_addr_bits-1];

    // ------------------------------------------------------------
    // Read with write-hazard forwarding
    // ------------------------------------------------------------
    function automatic logic [ahb_width-1:0] read_word(
        input logic [mem_addr_bits-3:0] word,
        input logic [3:0]               be,
        input mem_wr_t                  pend,
        input logic [ahb_width-1:0]     pend_data
    );
        logic [ahb_width-1:0] rdat;
        logic                 hit;
        hit = pend.en && (pend.word == word);
        for (int i = 0; i < 4; i++) begin
            if (!be[i]) begin
                rdat[8*i +: 8] = 8'h00;
            end else if (hit && pend.be[i]) begin
                rdat[8*i +: 8] = pend_data[8*i +: 8];
            end else begin
                rdat[8*i +: 8] = mem[{word, 2'(i)}];
            end
        end
        return rdat;
    endfunction

    // Instruction fetch always takes the whole word
    always_comb begin
        i_data = read_word(i_word, 4'b1111, wr, wdata);
    end

    always_comb begin
        d_data = read_word(d_word, d_be, wr, wdata);
    end

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr.be[i]) begin
                    mem[{wr.word, 2'(i)}] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: verilog/ahb_dual_mem.sv
/*
 * Dual-port AHB-Lite memory model, instruction fetch plus data port.
 * Ready patterns are sampled during reset, a zero pattern means no wait states.
 */

`timescale 1ns/1ps

module ahb_dual_mem import ahb_mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ahb_req_t                 imem_req,
    output ahb_rsp_t                 imem_rsp,
    input  logic [31:0]              imem_ready_pattern,
    input  ahb_req_t                 dmem_req,
    input  logic [ahb_width-1:0]     dmem_hwdata,
    output ahb_rsp_t                 dmem_rsp,
    input  logic [31:0]              dmem_ready_pattern,
    output logic [irq_lines_num-1:0] irq_lines
);

    logic                     imem_ready;
    logic                     dmem_ready;
    logic [mem_addr_bits-3:0] imem_word;
    logic [ahb_width-1:0]     imem_data;
    logic [mem_addr_bits-3:0] dmem_word;
    logic [3:0]               dmem_be;
    logic [ahb_width-1:0]     dmem_data;
    mem_wr_t                  dmem_wr;
    logic [ahb_width-1:0]     err_ptr;

    // ------------------------------------------------------------
    // Ready pacing, one per port
    // ------------------------------------------------------------
    ahb_ready_pacer u_imem_pacer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pattern (imem_ready_pattern),
        .ready   (imem_ready)
    );

    ahb_ready_pacer u_dmem_pacer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pattern (dmem_ready_pattern),
        .ready   (dmem_ready)
    );

    // ------------------------------------------------------------
    // Port controllers and shared array
    // ------------------------------------------------------------
    ahb_ifetch_port u_ifetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (imem_req),
        .ready   (imem_ready),
        .err_ptr (err_ptr),
        .rd_word (imem_word),
        .rd_data (imem_data),
        .rsp     (imem_rsp)
    );

    ahb_data_port u_data (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (dmem_req),
        .hwdata    (dmem_hwdata),
        .ready     (dmem_ready),
        .rd_word   (dmem_word),
        .rd_be     (dmem_be),
        .rd_data   (dmem_data),
        .wr        (dmem_wr),
        .err_ptr   (err_ptr),
        .irq_lines (irq_lines),
        .rsp       (dmem_rsp)
    );

    ahb_mem_array u_array (
        .clk    (clk),
        .i_word (imem_word),
        .d_word (dmem_word),
        .d_be   (dmem_be),
        .i_data (imem_data),
        .d_data (dmem_data),
        .wr     (dmem_wr),
        .wdata  (dmem_hwdata)
    );

endmodule

// File: tb/tb_clk_gen.sv
/*
 * Clock and reset for the testbench, 20 ns period.
 * rst_n is low for 10 rising edges and released on a falling edge.
 */

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb/tb_ahb_dual_mem.sv
/*
 * Testbench for the dual-port AHB memory. Table entries run as one pipelined
 * stream, and an entry on the other port starts only once the current one ends.
 * Expected words come from a reference byte model filled while the table is built.
 */

`timescale 1ns/1ps

module tb_ahb_dual_mem import ahb_mem_pkg::*; ();

    logic                     clk;
    logic                     rst_n;
    ahb_req_t                 imem_req;
    ahb_req_t                 dmem_req;
    ahb_rsp_t                 imem_rsp;
    ahb_rsp_t                 dmem_rsp;
    logic [ahb_width-1:0]     dmem_hwdata;
    logic [31:0]              imem_ready_pattern;
    logic [31:0]              dmem_ready_pattern;
    logic [irq_lines_num-1:0] irq_lines;

    // Stimulus and expected values, port 1 is instruction fetch
    string                    t_name  [0:63];
    bit                       t_port  [0:63];
    bit                       t_wr    [0:63];
    logic [31:0]              t_addr  [0:63];
    hsize_e                   t_size  [0:63];
    logic [31:0]              t_wdata [0:63];
    logic [31:0]              t_data  [0:63];
    hresp_e                   t_resp  [0:63];
    int                       n_tests;
    bit                       table_ready;

    logic [7:0]               ref_mem [0:2**mem_addr_bits-1];
    logic [irq_lines_num-1:0] ref_irq;
    logic [31:0]              ref_err_ptr;

    int                       a_idx;
    int                       d_idx;
    int                       d_cyc;
    int                       d_waits;
    int                       cyc;
    bit                       d_done;
    bit                       present;
    logic [irq_lines_num-1:0] rt_irq;
    int                       n_pass;
    int                       n_fail;
    int                       n_other;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ahb_dual_mem i_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .imem_req           (imem_req),
        .imem_rsp           (imem_rsp),
        .imem_ready_pattern (imem_ready_pattern),
        .dmem_req           (dmem_req),
        .dmem_hwdata        (dmem_hwdata),
        .dmem_rsp           (dmem_rsp),
        .dmem_ready_pattern (dmem_ready_pattern),
        .irq_lines          (irq_lines)
    );

    // ------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------
    function automatic logic [3:0] lane_mask(input hsize_e size, input logic [1:0] off);
        logic [3:0] m;
        int         n;
        n = (size == hsize_half) ? 2 : 1;
        for (int i = 0; i < 4; i++) begin
            m[i] = (size == hsize_word) || ((i >= off) && (i < off + n));
        end
        return m;
    endfunction

    // Pattern bit for a cycle counted from reset release
    function automatic bit ready_at(input logic [31:0] pat, input int c);
        return (pat == 32'h0) || pat[c % 32];
    endfunction

    function automatic int waits_after(input logic [31:0] pat, input int acc_cyc);
        int n;
        n = 0;
        while ((n < 32) && !ready_at(pat, acc_cyc + 1 + n)) begin
            n++;
        end
        return n;
    endfunction

    task automatic add_test(input string name, input bit port, input bit wr,
                            input logic [31:0] addr, input hsize_e size,
                            input logic [31:0] wdata);
        logic [3:0]  be;
        logic [31:0] rdata;
        bit          err;
        err   = (addr == mem_err_addr) || (addr == ref_err_ptr);
        be    = port ? 4'hF : lane_mask(size, addr[1:0]);
        rdata = '0;
        if (err) begin
            rdata = '0;
        end else if (!port && (addr == irq_addr)) begin
            if (wr) begin
                ref_irq = wdata[irq_lines_num-1:0];
            end else begin
                rdata[irq_lines_num-1:0] = ref_irq;
            end
        end else if (!port && (addr == err_ptr_addr)) begin
            if (wr) begin
                ref_err_ptr = wdata;
            end else begin
                rdata = ref_err_ptr;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (be[i] && wr) begin
                    ref_mem[{addr[mem_addr_bits-1:2], 2'(i)}] = wdata[8*i +: 8];
                end else if (be[i]) begin
                    rdata[8*i +: 8] = ref_mem[{addr[mem_addr_bits-1:2], 2'(i)}];
                end
            end
        end
        t_name[n_tests]  = name;
        t_port[n_tests]  = port;
        t_wr[n_tests]    = wr;
        t_addr[n_tests]  = addr;
        t_size[n_tests]  = size;
        t_wdata[n_tests] = wdata;
        t_data[n_tests]  = rdata;
        t_resp[n_tests]  = err ? hresp_error : hresp_okay;
        n_tests++;
    endtask

    // Columns: name, port, write, address, size, write data
    task automatic build_table();
        add_test("d_wr_word_000",   0, 1, 32'h0000_0000, hsize_word, 32'h1122_3344);
        add_test("d_rd_word_000",   0, 0, 32'h0000_0000, hsize_word, 32'h0);
        // Byte lanes at every offset
        add_test("d_wr_byte_010",   0, 1, 32'h0000_0010, hsize_byte, 32'hDEAD_BE11);
        add_test("d_wr_byte_011",   0, 1, 32'h0000_0011, hsize_byte, 32'hDEAD_22EF);
        add_test("d_wr_byte_012",   0, 1, 32'h0000_0012, hsize_byte, 32'hDE33_BEEF);
        add_test("d_wr_byte_013",   0, 1, 32'h0000_0013, hsize_byte, 32'h44AD_BEEF);
        add_test("d_rd_word_010",   0, 0, 32'h0000_0010, hsize_word, 32'h0);
        add_test("d_rd_byte_011",   0, 0, 32'h0000_0011, hsize_byte, 32'h0);
        add_test("d_rd_byte_013",   0, 0, 32'h0000_0013, hsize_byte, 32'h0);
        // Halfwords, offset 3 keeps only the top lane
        add_test("d_wr_half_020",   0, 1, 32'h0000_0020, hsize_half, 32'h0000_5566);
        add_test("d_wr_half_022",   0, 1, 32'h0000_0022, hsize_half, 32'h7788_0000);
        add_test("d_rd_word_020a",  0, 0, 32'h0000_0020, hsize_word, 32'h0);
        add_test("d_wr_half_021",   0, 1, 32'h0000_0021, hsize_half, 32'h00AB_CD00);
        add_test("d_wr_half_023",   0, 1, 32'h0000_0023, hsize_half, 32'hEE00_0000);
        add_test("d_rd_word_020b",  0, 0, 32'h0000_0020, hsize_word, 32'h0);
        add_test("d_rd_half_022",   0, 0, 32'h0000_0022, hsize_half, 32'h0);
        add_test("d_rd_half_021",   0, 0, 32'h0000_0021, hsize_half, 32'h0);
        add_test("d_rd_byte_020",   0, 0, 32'h0000_0020, hsize_byte, 32'h0);
        // Reads right behind a write to the same word
        add_test("d_wr_word_030",   0, 1, 32'h0000_0030, hsize_word, 32'hCAFE_F00D);
        add_test("d_rd_fwd_030",    0, 0, 32'h0000_0030, hsize_word, 32'h0);
        add_test("d_wr_byte_032",   0, 1, 32'h0000_0032, hsize_byte, 32'h0099_0000);
        add_test("d_rd_merge_030",  0, 0, 32'h0000_0030, hsize_word, 32'h0);
        add_test("i_rd_030",        1, 0, 32'h0000_0030, hsize_word, 32'h0);
        add_test("d_wr_word_040",   0, 1, 32'h0000_0040, hsize_word, 32'h0BAD_F00D);
        add_test("i_rd_fwd_040",    1, 0, 32'h0000_0040, hsize_word, 32'h0);
        add_test("d_wr_wrap_1050",  0, 1, 32'h0000_1050, hsize_word, 32'h1357_9BDF);
        add_test("d_rd_wrap_050",   0, 0, 32'h0000_0050, hsize_word, 32'h0);
        // Fixed error address, then a moved error pointer
        add_test("d_rd_err_fixed",  0, 0, mem_err_addr,  hsize_word, 32'h0);
        add_test("d_wr_err_fixed",  0, 1, mem_err_addr,  hsize_word, 32'h1234_5678);
        add_test("i_rd_err_fixed",  1, 0, mem_err_addr,  hsize_word, 32'h0);
        add_test("d_wr_word_060",   0, 1, 32'h0000_0060, hsize_word, 32'h6060_6060);
        add_test("d_wr_err_ptr",    0, 1, err_ptr_addr,  hsize_word, 32'h0000_0060);
        add_test("d_rd_err_ptr",    0, 0, err_ptr_addr,  hsize_word, 32'h0);
        add_test("d_wr_err_060",    0, 1, 32'h0000_0060, hsize_word, 32'hFFFF_FFFF);
        add_test("d_rd_err_060",    0, 0, 32'h0000_0060, hsize_word, 32'h0);
        add_test("i_rd_err_060",    1, 0, 32'h0000_0060, hsize_word, 32'h0);
        add_test("d_rd_err_fixed2", 0, 0, mem_err_addr,  hsize_word, 32'h0);
        add_test("d_wr_err_ptr_rst", 0, 1, err_ptr_addr, hsize_word, mem_err_addr);
        add_test("d_rd_word_060",   0, 0, 32'h0000_0060, hsize_word, 32'h0);
        add_test("i_rd_060",        1, 0, 32'h0000_0060, hsize_word, 32'h0);
        // Interrupt lines
        add_test("d_wr_irq_a5",     0, 1, irq_addr,      hsize_word, 32'h0000_01A5);
        add_test("d_rd_irq_a5",     0, 0, irq_addr,      hsize_word, 32'h0);
        add_test("d_wr_irq_3c",     0, 1, irq_addr,      hsize_word, 32'h0000_003C);
        add_test("d_rd_irq_3c",     0, 0, irq_addr,      hsize_word, 32'h0);
        add_test("i_rd_000",        1, 0, 32'h0000_0000, hsize_word, 32'h0);
        add_test("i_rd_010",        1, 0, 32'h0000_0010, hsize_word, 32'h0);
        add_test("i_rd_020",        1, 0, 32'h0000_0020, hsize_word, 32'h0);
    endtask

    // ------------------------------------------------------------
    // Bus driving and response checks
    // ------------------------------------------------------------
    function automatic ahb_req_t idle_req();
        ahb_req_t r;
        r.htrans     = htrans_idle;
        r.haddr.full = '0;
        r.hwrite     = 1'b0;
        r.hsize      = hsize_word;
        return r;
    endfunction

    task automatic drive_request(input int idx);
        ahb_req_t r;
        // SEQ when the port repeats, both start a transfer
        r.htrans     = ((idx > 0) && (t_port[idx-1] == t_port[idx])) ? htrans_seq
                                                                      : htrans_nonseq;
        r.haddr.full = t_addr[idx];
        r.hwrite     = t_wr[idx];
        r.hsize      = t_size[idx];
        if (t_port[idx]) begin
            imem_req = r;
        end else begin
            dmem_req = r;
        end
    endtask

    task automatic check_result(input int idx, input ahb_rsp_t rsp, input int waits,
                                input int acc_cyc);
        int exp_waits;
        bit ok;
        exp_waits = waits_after(t_port[idx] ? imem_ready_pattern : dmem_ready_pattern,
                                acc_cyc);
        ok = 1'b1;
        assert (rsp.hresp === t_resp[idx]) else begin
            $display("[FAIL] %s hresp expected %0d actual %0d",
                     t_name[idx], t_resp[idx], rsp.hresp);
            ok = 1'b0;
        end
        assert (rsp.hrdata === t_data[idx]) else begin
            $display("[FAIL] %s hrdata expected %h actual %h",
                     t_name[idx], t_data[idx], rsp.hrdata);
            ok = 1'b0;
        end
        assert (waits == exp_waits) else begin
            $display("[FAIL] %s wait cycles expected %0d actual %0d",
                     t_name[idx], exp_waits, waits);
            ok = 1'b0;
        end
        if (ok) begin
            n_pass++;
            $display("[PASS] %s after %0d wait cycles", t_name[idx], waits);
        end else begin
            n_fail++;
        end
    endtask

    // ------------------------------------------------------------
    // Main stream
    // ------------------------------------------------------------
    initial begin
        imem_ready_pattern = 32'hFFFF_FFFF;
        dmem_ready_pattern = 32'h0F0F_6DB7;
        imem_req           = idle_req();
        dmem_req           = idle_req();
        dmem_hwdata        = '0;
        ref_irq            = '0;
        ref_err_ptr        = mem_err_addr;
        rt_irq             = '0;
        n_tests            = 0;
        n_pass             = 0;
        n_fail             = 0;
        n_other            = 0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        cyc   = 0;
        a_idx = 0;
        d_idx = -1;
        while ((a_idx < n_tests) || (d_idx >= 0)) begin
            @(negedge clk);
            cyc++;
            assert (imem_rsp.hready === ready_at(imem_ready_pattern, cyc)) else begin
                $display("instruction port hready does not follow its pattern in cycle %0d",
                         cyc);
                n_other++;
            end
            assert (dmem_rsp.hready === ready_at(dmem_ready_pattern, cyc)) else begin
                $display("data port hready does not follow its pattern in cycle %0d", cyc);
                n_other++;
            end
            assert (irq_lines === rt_irq) else begin
                $display("irq_lines show %h while %h was last written", irq_lines, rt_irq);
                n_other++;
            end
            // Data phase ends only in a cycle with hready high
            d_done = 1'b0;
            if (d_idx >= 0) begin
                if (t_port[d_idx] ? imem_rsp.hready : dmem_rsp.hready) begin
                    check_result(d_idx, t_port[d_idx] ? imem_rsp : dmem_rsp, d_waits, d_cyc);
                    if (!t_port[d_idx] && t_wr[d_idx] && (t_addr[d_idx] == irq_addr)
                        && (t_resp[d_idx] == hresp_okay)) begin
                        rt_irq = t_wdata[d_idx][irq_lines_num-1:0];
                    end
                    d_done = 1'b1;
                end else begin
                    d_waits++;
                end
            end
            present = (a_idx < n_tests)
                   && ((d_idx < 0) || d_done || (t_port[a_idx] == t_port[d_idx]));
            if ((d_idx >= 0) && !t_port[d_idx]) begin
                dmem_hwdata = t_wdata[d_idx];
            end else begin
                dmem_hwdata = '0;
            end
            imem_req = idle_req();
            dmem_req = idle_req();
            if (present) begin
                drive_request(a_idx);
            end
            if (d_done) begin
                d_idx = -1;
            end
            if (present && (t_port[a_idx] ? imem_rsp.hready : dmem_rsp.hready)) begin
                d_idx   = a_idx;
                d_cyc   = cyc;
                d_waits = 0;
                a_idx++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d other errors",
                 n_tests, n_pass, n_fail, n_other);
        if ((n_fail == 0) && (n_other == 0) && (n_pass == n_tests)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Stops a stalled stream, 40 cycles per table entry
    initial begin
        wait (table_ready);
        #(n_tests * 40 * 20);
        $display("watchdog expired before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: vlog.f
verilog/ahb_mem_pkg.sv
verilog/ahb_ready_pacer.sv
verilog/ahb_ifetch_port.sv
verilog/ahb_data_port.sv
verilog/ahb_mem_array.sv
verilog/ahb_dual_mem.sv
tb/tb_clk_gen.sv
tb/tb_ahb_dual_mem.sv
